// ==== Bender.yml ====
package:
  name: recip

sources:
  - files:
      - src/recip_pkg.sv
      - src/newton_step.sv
      - src/mant_path.sv
      - src/exp_class_path.sv
      - src/result_pack.sv
      - src/credit_out_buffer.sv
      - src/recip_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/recip_tb.sv

// ==== compile.f ====
+incdir+dv
src/recip_pkg.sv
src/newton_step.sv
src/mant_path.sv
src/exp_class_path.sv
src/result_pack.sv
src/credit_out_buffer.sv
src/recip_top.sv
dv/recip_tb.sv

// ==== dv/recip_tb_util.svh ====
`ifndef RECIP_TB_UTIL_SVH
`define RECIP_TB_UTIL_SVH

// lcg step, full 32-bit state
function automatic logic [31:0] next_random();
   rng_state = rng_state * 32'd1664525 + 32'd1013904223;
   return rng_state;
endfunction

// operand with exponent field 1 to 252, any mantissa
function automatic fp32_t random_normal();
   logic [31:0] r;
   logic [31:0] r2;
   fp32_t       f;
   r = next_random();
   r2 = next_random();
   f.sign = r[31];
   f.exp = 8'(1 + r[23:8] % 252);
   f.man = r2[31:9];
   return f;
endfunction

function automatic real fp_magnitude(input fp32_t f);
   real frac;
   frac = 1.0 + $itor(f.man) / 8388608.0;
   return frac * (2.0 ** ($itor(f.exp) - 127.0));
endfunction

function automatic logic expect_exception(input fp32_t a);
   return (a.exp == 8'hff) && (a.man != '0);
endfunction

// returns 1 when the result is fully determined, else only a tolerance applies
function automatic logic exact_result(input fp32_t a, output fp32_t r);
   r.sign = a.sign;
   r.exp = 8'h00;
   r.man = '0;
   if (a.exp == 8'hff) begin
      // infinity gives the signed zero already set up
      if (a.man != '0) begin
         r.exp = 8'hff;
         r.man = {1'b1, a.man[MAN_W-2:0]};
      end
      return 1'b1;
   end
   if (a.exp == 8'h00) begin
      r.exp = 8'hff;
      return 1'b1;
   end
   if (a.exp >= 8'd253) begin
      return 1'b1;
   end
   if (a.man == '0) begin
      r.exp = 8'd254 - a.exp;
      return 1'b1;
   end
   return 1'b0;
endfunction

`endif

// ==== dv/recip_tb.sv ====
`default_nettype none

module recip_tb import recip_pkg::*; ();
   localparam int FIFO_DEPTH = 8;
   localparam int WAIT_LIMIT = 4000;
   localparam real TOL = 1.0 / 1048576.0;

   logic        clk;
   logic        rst;
   logic        in_valid;
   fp32_t       in_data;
   logic        in_credit;
   logic        out_valid;
   fp32_t       out_data;
   logic        out_exception;
   logic        out_credit;

   logic [31:0] rng_state;
   fp32_t       sent_q [$];
   int          in_credits;
   int          out_credits_held;
   int          credits_returned;
   int          delivered;
   bit          grant_on;
   int          burst_left;
   int          pause_left;
   string       test_name;

   logic [31:0] special_ops [14] = '{
      32'h7fc00000, 32'hffa12345, 32'h7f800001, 32'h7f800000, 32'hff800000,
      32'h00000000, 32'h80000000, 32'h00000001, 32'h807fffff, 32'h7e800000,
      32'hfe812345, 32'h7f7fffff, 32'hff000000, 32'h3f800000
   };

   `include "recip_tb_util.svh"

   recip_top #(
      .SEED_BITS  (8),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) dut_i (
      .clk           (clk),
      .rst           (rst),
      .in_valid      (in_valid),
      .in_data       (in_data),
      .in_credit     (in_credit),
      .out_valid     (out_valid),
      .out_data      (out_data),
      .out_exception (out_exception),
      .out_credit    (out_credit)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic stop_run(input string reason);
      $display("%s", reason);
      $display(">>> FAIL");
      $fatal(1);
   endtask

   task automatic value_mismatch(input string name, input logic [31:0] want,
                                 input logic [31:0] got);
      stop_run($sformatf("ERR %s expected %h actual %h", name, want, got));
   endtask

   task automatic check_result(input fp32_t op, input fp32_t res, input logic exc);
      fp32_t want;
      logic  is_exact;
      real   prod;
      is_exact = exact_result(op, want);
      if (is_exact) begin
         assert (res == want) else value_mismatch(test_name, want, res);
      end else begin
         prod = fp_magnitude(op) * fp_magnitude(res);
         assert (res.sign == op.sign) else value_mismatch(test_name, {op.sign, res[30:0]}, res);
         assert (prod > 1.0 - TOL && prod < 1.0 + TOL)
            else stop_run($sformatf("ERR %s expected product 1.0 actual %0.9f for %h -> %h",
                                    test_name, prod, op, res));
      end
      assert (exc == expect_exception(op))
         else value_mismatch({test_name, " exception"}, expect_exception(op), exc);
   endtask

   task automatic check_outputs();
      fp32_t op;
      if (in_credit) begin
         in_credits++;
         credits_returned++;
      end
      assert (in_credits <= FIFO_DEPTH) else stop_run("more input credits returned than spent");
      assert (credits_returned <= delivered)
         else stop_run("input credit returned before its result left the FIFO");
      assert (out_valid || !out_exception) else stop_run("out_exception high without out_valid");
      if (out_valid) begin
         assert (out_credits_held > 0) else stop_run("out_valid with no output credit granted");
         assert (sent_q.size() > 0) else stop_run("result delivered with no operand outstanding");
         op = sent_q.pop_front();
         out_credits_held--;
         delivered++;
         check_result(op, out_data, out_exception);
      end
   endtask

   task automatic grant_credits();
      out_credit = 1'b0;
      if (grant_on) begin
         if (pause_left > 0) begin
            pause_left--;
         end else if (burst_left > 0) begin
            out_credit = 1'b1;
            out_credits_held++;
            burst_left--;
         end else begin
            burst_left = 1 + int'(next_random() % 6);
            // long pause now and then so the FIFO fills up
            if (next_random() % 4 == 0) begin
               pause_left = 20 + int'(next_random() % 40);
            end else begin
               pause_left = int'(next_random() % 3);
            end
         end
      end
   endtask

   task automatic tick();
      @(negedge clk);
      in_valid = 1'b0;
      check_outputs();
      grant_credits();
   endtask

   task automatic send_operand(input fp32_t op);
      int waited;
      waited = 0;
      tick();
      while (in_credits == 0) begin
         assert (waited < WAIT_LIMIT) else stop_run("timeout waiting for an input credit");
         waited++;
         tick();
      end
      in_valid = 1'b1;
      in_data = op;
      in_credits--;
      sent_q.push_back(op);
   endtask

   // all results out and every input credit back
   task automatic wait_drained();
      int waited;
      waited = 0;
      while (sent_q.size() != 0 || in_credits != FIFO_DEPTH) begin
         assert (waited < WAIT_LIMIT) else stop_run("timeout waiting for outstanding results");
         waited++;
         tick();
      end
   endtask

   initial begin
      fp32_t       op;
      logic [31:0] r;
      int          ret_base;
      int          del_base;
      rst = 1'b1;
      in_valid = 1'b0;
      in_data = '0;
      out_credit = 1'b0;
      rng_state = 32'hccae0818;
      in_credits = FIFO_DEPTH;
      out_credits_held = 0;
      credits_returned = 0;
      delivered = 0;
      grant_on = 1'b1;
      burst_left = 0;
      pause_left = 0;
      test_name = "reset";
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      assert (!in_credit && !out_valid && !out_exception)
         else stop_run("outputs not idle after reset");

      test_name = "special";
      foreach (special_ops[i]) send_operand(special_ops[i]);
      wait_drained();

      test_name = "pow2";
      for (int e = 1; e <= 252; e++) begin
         r = next_random();
         op.sign = r[31];
         op.exp = 8'(e);
         op.man = '0;
         send_operand(op);
      end
      wait_drained();

      test_name = "large_exp";
      for (int i = 0; i < 40; i++) begin
         r = next_random();
         op = random_normal();
         op.exp = r[20] ? 8'd254 : 8'd253;
         send_operand(op);
      end
      wait_drained();

      test_name = "random";
      repeat (1500) send_operand(random_normal());
      wait_drained();

      test_name = "mixed";
      repeat (1000) send_operand(next_random());
      wait_drained();

      // use up leftover output credits so the burst stays in the FIFO
      test_name = "burst";
      grant_on = 1'b0;
      while (out_credits_held > 0) begin
         send_operand(random_normal());
         wait_drained();
      end
      ret_base = credits_returned;
      del_base = delivered;
      repeat (FIFO_DEPTH) send_operand(random_normal());
      assert (in_credits == 0) else value_mismatch("burst input credits", 0, in_credits);
      repeat (4 * MANT_LATENCY) tick();
      assert (delivered == del_base) else value_mismatch("burst held", del_base, delivered);
      assert (credits_returned == ret_base)
         else value_mismatch("burst early credit", ret_base, credits_returned);
      grant_on = 1'b1;
      wait_drained();

      $display(">>> PASS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== src/credit_out_buffer.sv ====
`default_nettype none

module credit_out_buffer import recip_pkg::*; #(
   parameter int FIFO_DEPTH = 8
) (
   input  wire        clk,
   input  wire        rst,
   input  wire        wr_valid,
   input  wire fp32_t wr_data,
   input  wire        wr_exception,
   output logic       in_credit,
   output logic       out_valid,
   output fp32_t      out_data,
   output logic       out_exception,
   input  wire        out_credit
);
   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
   localparam int CREDIT_W = 16;

   fp32_t               data_mem [FIFO_DEPTH];
   logic                exc_mem [FIFO_DEPTH];
   logic [PTR_W-1:0]    wr_ptr;
   logic [PTR_W-1:0]    rd_ptr;
   logic [CNT_W-1:0]    fill;
   logic [CREDIT_W-1:0] credits;
   logic                empty;

   assign empty = (fill == '0);

   // one result per cycle while output credits last
   assign out_valid = (credits != '0) && !empty;
   assign out_data = data_mem[rd_ptr];
   assign out_exception = out_valid && exc_mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (wr_valid) begin
         data_mem[wr_ptr] <= wr_data;
         exc_mem[wr_ptr] <= wr_exception;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill <= '0;
         credits <= '0;
         in_credit <= 1'b0;
      end else begin
         if (wr_valid) begin
            wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (out_valid) begin
            rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         fill <= fill + {{(CNT_W-1){1'b0}}, wr_valid} - {{(CNT_W-1){1'b0}}, out_valid};
         credits <= credits + {{(CREDIT_W-1){1'b0}}, out_credit}
                    - {{(CREDIT_W-1){1'b0}}, out_valid};
         // slot freed, hand a credit back to the producer
         in_credit <= out_valid;
      end
   end

   a_no_overflow : assert property (
      @(posedge clk) disable iff (rst) wr_valid |-> fill != CNT_W'(FIFO_DEPTH)
   );

   a_credit_held : assert property (
      @(posedge clk) disable iff (rst) (credits == '0 && !out_credit) |=> !out_valid
   );

endmodule

`default_nettype wire

// ==== src/exp_class_path.sv ====
`default_nettype none

module exp_class_path import recip_pkg::*; (
   input  wire        clk,
   input  wire        rst,
   input  wire        in_valid,
   input  wire fp32_t in_data,
   output logic       info_valid,
   output exp_info_t  info
);
   exp_info_t               info_d;
   exp_info_t               info_q [MANT_LATENCY];
   logic [MANT_LATENCY-1:0] vld_q;

   always_comb begin
      info_d.sign = in_data.sign;
      info_d.payload = in_data.man[MAN_W-2:0];
      info_d.pow2 = (in_data.man == '0);
      // results below the normal range go to zero
      info_d.flush = (in_data.exp >= EXP_BIAS_RCP);
      info_d.exp = EXP_BIAS_RCP - in_data.exp + {{(EXP_W-1){1'b0}}, info_d.pow2};
      if (in_data.exp == '1) begin
         info_d.cls = (in_data.man == '0) ? FP_INF : FP_NAN;
      end else if (in_data.exp == '0) begin
         info_d.cls = FP_ZERO;
      end else begin
         info_d.cls = FP_NORMAL;
      end
      info_d.exc = (info_d.cls == FP_NAN);
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         vld_q <= '0;
      end else begin
         vld_q <= {vld_q[MANT_LATENCY-2:0], in_valid};
      end
   end

   // same depth as seed stage plus newton steps
   always_ff @(posedge clk) begin
      info_q[0] <= info_d;
      for (int i = 1; i < MANT_LATENCY; i++) begin
         info_q[i] <= info_q[i-1];
      end
   end

   assign info_valid = vld_q[MANT_LATENCY-1];
   assign info = info_q[MANT_LATENCY-1];

   a_info_latency : assert property (
      @(posedge clk) disable iff (rst) in_valid |-> ##MANT_LATENCY info_valid
   );

endmodule

`default_nettype wire

// ==== src/mant_path.sv ====
`default_nettype none

module mant_path import recip_pkg::*; #(
   parameter int SEED_BITS = 8
) (
   input  wire             clk,
   input  wire             rst,
   input  wire             in_valid,
   input  wire [MAN_W-1:0] man,
   output logic            rcp_valid,
   output rcp_t            rcp
);
   rcp_t                  seed_rom [2**SEED_BITS];
   logic                  seed_vld;
   logic [MAN_W:0]        seed_man;
   rcp_t                  seed_rcp;
   logic [NEWTON_STEPS:0] vld_s;
   logic [MAN_W:0]        man_s [NEWTON_STEPS+1];
   rcp_t                  rcp_s [NEWTON_STEPS+1];

   // table built from the package function
   for (genvar i = 0; i < 2**SEED_BITS; i++) begin : g_seed
      assign seed_rom[i] = recip_seed(i, SEED_BITS);
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         seed_vld <= 1'b0;
      end else begin
         seed_vld <= in_valid;
      end
   end

   // mantissa carries its hidden one from here on
   always_ff @(posedge clk) begin
      seed_man <= {1'b1, man};
      seed_rcp <= seed_rom[man[MAN_W-1 -: SEED_BITS]];
   end

   assign vld_s[0] = seed_vld;
   assign man_s[0] = seed_man;
   assign rcp_s[0] = seed_rcp;

   for (genvar i = 0; i < NEWTON_STEPS; i++) begin : g_newton
      newton_step step_i (
         .clk       (clk),
         .rst       (rst),
         .in_valid  (vld_s[i]),
         .man_in    (man_s[i]),
         .rcp_in    (rcp_s[i]),
         .out_valid (vld_s[i+1]),
         .man_out   (man_s[i+1]),
         .rcp_out   (rcp_s[i+1])
      );
   end

   assign rcp_valid = vld_s[NEWTON_STEPS];
   assign rcp = rcp_s[NEWTON_STEPS];

endmodule

`default_nettype wire

// ==== src/newton_step.sv ====
`default_nettype none

module newton_step import recip_pkg::*; (
   input  wire            clk,
   input  wire            rst,
   input  wire            in_valid,
   input  wire [MAN_W:0]  man_in,
   input  wire rcp_t      rcp_in,
   output logic           out_valid,
   output logic [MAN_W:0] man_out,
   output rcp_t           rcp_out
);
   localparam int PROD_W = MAN_W + 1 + FRAC_W;
   localparam int CORR_W = PROD_W + 1;
   localparam int REF_W = 2 * FRAC_W + 1;

   logic [PROD_W-1:0] prod_mr;
   logic [CORR_W-1:0] corr;
   logic [FRAC_W:0]   corr_t;
   logic [REF_W-1:0]  prod_rc;
   logic              round_up;
   logic [FRAC_W:0]   rounded;
   rcp_t              rcp_next;

   always_comb begin
      prod_mr = man_in * rcp_in;
      // 2 - m*r, close to 1.0
      corr = {1'b1, {PROD_W{1'b0}}} - {1'b0, prod_mr};
      corr_t = corr[CORR_W-1 -: FRAC_W+1];
      prod_rc = rcp_in * corr_t;
      // nearest even on the dropped bits
      round_up = prod_rc[FRAC_W-2] & ((|prod_rc[FRAC_W-3:0]) | prod_rc[FRAC_W-1]);
      rounded = {1'b0, prod_rc[2*FRAC_W-2 -: FRAC_W]} + {{FRAC_W{1'b0}}, round_up};
      if (rounded[FRAC_W] || (|prod_rc[REF_W-1 -: 2])) begin
         rcp_next = '1;
      end else begin
         rcp_next = rounded[FRAC_W-1:0];
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      man_out <= man_in;
      rcp_out <= rcp_next;
   end

endmodule

`default_nettype wire

// ==== src/recip_pkg.sv ====
`default_nettype none

package recip_pkg;

   localparam int EXP_W = 8;
   localparam int MAN_W = 23;

   // reciprocal estimate, one integer bit
   localparam int FRAC_W = 26;

   localparam int NEWTON_STEPS = 2;
   localparam int MANT_LATENCY = 1 + NEWTON_STEPS;

   // 126 + 127, result exponent is this minus the input field
   localparam logic [EXP_W-1:0] EXP_BIAS_RCP = 8'd253;

   typedef logic [FRAC_W-1:0] rcp_t;

   typedef struct packed {
      logic             sign;
      logic [EXP_W-1:0] exp;
      logic [MAN_W-1:0] man;
   } fp32_t;

   typedef enum logic [1:0] {
      FP_NORMAL = 2'd0,
      FP_ZERO   = 2'd1,
      FP_INF    = 2'd2,
      FP_NAN    = 2'd3
   } fp_class_e;

   typedef struct packed {
      fp_class_e        cls;
      logic             sign;
      logic [EXP_W-1:0] exp;
      logic             pow2;
      logic             flush;
      logic [MAN_W-2:0] payload;
      logic             exc;
   } exp_info_t;

   // 2 / (1 + idx / 2^width) in Q1.25, rounded
   function automatic rcp_t recip_seed(input int unsigned idx, input int unsigned width);
      longint unsigned num;
      longint unsigned den;
      longint unsigned q;
      num = 64'd1 << (FRAC_W + width);
      den = (64'd1 << width) + idx;
      q = (num + den / 2) / den;
      // idx 0 would give exactly 2.0
      if (q >= (64'd1 << FRAC_W)) begin
         q = (64'd1 << FRAC_W) - 1;
      end
      return rcp_t'(q);
   endfunction

endpackage

`default_nettype wire

// ==== src/recip_top.sv ====
`default_nettype none

module recip_top import recip_pkg::*; #(
   parameter int SEED_BITS = 8,
   parameter int FIFO_DEPTH = 8
) (
   input  wire        clk,
   input  wire        rst,
   input  wire        in_valid,
   input  wire fp32_t in_data,
   output logic       in_credit,
   output logic       out_valid,
   output fp32_t      out_data,
   output logic       out_exception,
   input  wire        out_credit
);
   logic      rcp_valid;
   rcp_t      rcp;
   logic      info_valid;
   exp_info_t info;
   logic      res_valid;
   fp32_t     res_data;
   logic      res_exception;

   // mantissa and exponent paths run side by side
   mant_path #(
      .SEED_BITS (SEED_BITS)
   ) mant_path_i (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (in_valid),
      .man       (in_data.man),
      .rcp_valid (rcp_valid),
      .rcp       (rcp)
   );

   exp_class_path exp_class_path_i (
      .clk        (clk),
      .rst        (rst),
      .in_valid   (in_valid),
      .in_data    (in_data),
      .info_valid (info_valid),
      .info       (info)
   );

   result_pack result_pack_i (
      .clk           (clk),
      .rst           (rst),
      .rcp_valid     (rcp_valid),
      .rcp           (rcp),
      .info_valid    (info_valid),
      .info          (info),
      .res_valid     (res_valid),
      .res_data      (res_data),
      .res_exception (res_exception)
   );

   credit_out_buffer #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) out_buffer_i (
      .clk           (clk),
      .rst           (rst),
      .wr_valid      (res_valid),
      .wr_data       (res_data),
      .wr_exception  (res_exception),
      .in_credit     (in_credit),
      .out_valid     (out_valid),
      .out_data      (out_data),
      .out_exception (out_exception),
      .out_credit    (out_credit)
   );

endmodule

`default_nettype wire

// ==== src/result_pack.sv ====
`default_nettype none

module result_pack import recip_pkg::*; (
   input  wire            clk,
   input  wire            rst,
   input  wire            rcp_valid,
   input  wire rcp_t      rcp,
   input  wire            info_valid,
   input  wire exp_info_t info,
   output logic           res_valid,
   output fp32_t          res_data,
   output logic           res_exception
);
   logic [MAN_W:0] man_rnd;
   logic           rnd_up;
   fp32_t          res_d;

   always_comb begin
      // drop the integer bit, keep 23 fraction bits, nearest even
      rnd_up = rcp[FRAC_W-MAN_W-2]
               & ((|rcp[FRAC_W-MAN_W-3:0]) | rcp[FRAC_W-MAN_W-1]);
      man_rnd = {1'b0, rcp[FRAC_W-2 -: MAN_W]} + {{MAN_W{1'b0}}, rnd_up};
      res_d.sign = info.sign;
      res_d.exp = info.exp;
      res_d.man = '0;
      case (info.cls)
         FP_NAN: begin
            res_d.exp = '1;
            res_d.man = {1'b1, info.payload};
         end
         FP_INF: res_d.exp = '0;
         FP_ZERO: res_d.exp = '1;
         default: begin
            if (info.flush) begin
               res_d.exp = '0;
            end else if (!info.pow2 && rcp[FRAC_W-1]) begin
               // rounding up to 2.0 bumps the exponent
               if (man_rnd[MAN_W]) begin
                  res_d.exp = info.exp + 1'b1;
               end else begin
                  res_d.man = man_rnd[MAN_W-1:0];
               end
            end
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         res_valid <= 1'b0;
         res_exception <= 1'b0;
      end else begin
         res_valid <= rcp_valid;
         res_exception <= rcp_valid & info.exc;
      end
   end

   always_ff @(posedge clk) begin
      res_data <= res_d;
   end

   a_paths_aligned : assert property (
      @(posedge clk) disable iff (rst) rcp_valid == info_valid
   );

endmodule

`default_nettype wire
